// ==== include/rv32_defines.svh ====
`ifndef RV32_DEFINES_SVH
`define RV32_DEFINES_SVH

// data and address width
`define XLEN 32

// register index width, 32 architectural registers
`define REG_ADDR_WIDTH 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// rv32i major opcodes, instr[6:0]
`define OPCODE_OP     7'b0110011
`define OPCODE_OP_IMM 7'b0010011
`define OPCODE_LOAD   7'b0000011
`define OPCODE_STORE  7'b0100011
`define OPCODE_BRANCH 7'b1100011
`define OPCODE_JAL    7'b1101111

`endif

// ==== hdl/rv32Pkg.sv ====
`include "rv32_defines.svh"

package rv32Pkg;

    // one machine word, pc or raw instruction
    typedef logic [`XLEN-1:0] wordT;

    // register index
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

    // J-type offset, bit 0 always zero
    typedef logic signed [20:0] jumpImmT;

    // B-type offset, bit 0 always zero
    typedef logic signed [12:0] branchImmT;

    // IF/ID payload
    typedef struct packed {
        wordT pc;
        wordT instr;
    } fetchPayloadT;

    // ID/EX and EX/MEM payload
    typedef struct packed {
        wordT      pc;
        wordT      instr;
        regAddrT   rd;
        logic      isLoad;
        logic      isJump;
        logic      isBranch;
        jumpImmT   jumpImm;
        branchImmT branchImm;
    } decodedPayloadT;

endpackage

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/1ns
`include "rv32_defines.svh"

module instrDecoder (
    input  logic                    ifValid,
    input  logic [`XLEN-1:0]        ifPc,
    input  logic [`XLEN-1:0]        ifInstr,
    output rv32Pkg::regAddrT        rs1,
    output rv32Pkg::regAddrT        rs2,
    output logic                    useRs1,
    output logic                    useRs2,
    output rv32Pkg::decodedPayloadT decoded
);

    logic [6:0]       opcode;
    rv32Pkg::regAddrT rdField;
    logic             readsBoth;
    logic             readsRs1Only;
    logic             writesNoRd;

    // fixed field positions, valid for every format
    assign opcode  = ifInstr[6:0];
    assign rdField = ifInstr[11:7];
    assign rs1     = ifInstr[19:15];
    assign rs2     = ifInstr[24:20];

    always_comb begin
        readsBoth    = 1'b0;
        readsRs1Only = 1'b0;
        writesNoRd   = 1'b0;
        // source usage per opcode
        // anything unlisted (jal, jalr, lui...) reads nothing for hazard purposes
        case (opcode)
            `OPCODE_OP: begin
                readsBoth = 1'b1;
            end
            `OPCODE_BRANCH, `OPCODE_STORE: begin
                readsBoth  = 1'b1;
                writesNoRd = 1'b1;
            end
            `OPCODE_OP_IMM, `OPCODE_LOAD: begin
                readsRs1Only = 1'b1;
            end
            default: begin
                readsBoth = 1'b0;
            end
        endcase

        decoded.pc       = ifPc;
        decoded.instr    = ifInstr;
        // stores and branches carry imm bits in the rd slot, so force x0
        decoded.rd       = writesNoRd ? '0 : rdField;
        // control flags only count for a live instruction
        decoded.isLoad   = ifValid && (opcode == `OPCODE_LOAD);
        decoded.isJump   = ifValid && (opcode == `OPCODE_JAL);
        decoded.isBranch = ifValid && (opcode == `OPCODE_BRANCH);
        // J-type offset reassembly
        decoded.jumpImm  = {ifInstr[31], ifInstr[19:12], ifInstr[20], ifInstr[30:21], 1'b0};
        // B-type offset reassembly
        decoded.branchImm = {ifInstr[31], ifInstr[7], ifInstr[30:25], ifInstr[11:8], 1'b0};
    end

    // a bubble in IF/ID must never raise a load-use stall
    assign useRs1 = ifValid && (readsBoth || readsRs1Only);
    assign useRs2 = ifValid && readsBoth;

endmodule

// ==== hdl/hazardDetection.sv ====
`timescale 1ns/1ns

module hazardDetection (
    input  logic             useRs1,
    input  logic             useRs2,
    input  rv32Pkg::regAddrT rs1,
    input  rv32Pkg::regAddrT rs2,
    input  logic             idValid,
    input  logic             idIsLoad,
    input  rv32Pkg::regAddrT idRd,
    input  logic             idIsJump,
    input  logic             exValid,
    input  logic             exIsBranch,
    input  logic             exBranchCond,
    output logic             stall,
    output logic             ifIdFlush,
    output logic             exFlush,
    output logic             branchTaken,
    output logic             jumpTaken
);

    logic rs1Match;
    logic rs2Match;
    logic loadUse;

    always_comb begin
        // IF/ID reads the register the load in ID/EX will write
        rs1Match = useRs1 && (idRd == rs1);
        rs2Match = useRs2 && (idRd == rs2);
        // x0 never carries a real value so it cannot create a hazard
        loadUse  = idValid && idIsLoad && (idRd != '0) && (rs1Match || rs2Match);

        // branch resolves in EX/MEM with the datapath compare
        branchTaken = exValid && exIsBranch && exBranchCond;
        // jal is known as soon as it sits in ID/EX
        jumpTaken   = idValid && idIsJump;

        // a taken branch squashes the load too, so its dependence is moot
        stall     = loadUse && !branchTaken;
        // jump kills IF/ID and ID/EX, branch also kills EX/MEM
        ifIdFlush = branchTaken || jumpTaken;
        exFlush   = branchTaken;

        // decoder never marks a jal as a load
        assert (!(stall && jumpTaken))
            else $error("load-use stall together with a jump in ID/EX");
    end

endmodule

// ==== hdl/pipeStageReg.sv ====
`timescale 1ns/1ns

module pipeStageReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    hold,
    input  logic    flush,
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);

    // valid bit, flush beats hold
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (flush) begin
            outValid <= 1'b0;
        end else if (!hold) begin
            outValid <= inValid;
        end
    end

    // payload follows the valid bit and only matters while outValid is high
    always_ff @(posedge clk) begin
        if (!hold) begin
            outData <= inData;
        end
    end

    // hazard logic must never ask a stage to keep and drop the same entry
    holdFlushExclusive: assert property (
        @(posedge clk) disable iff (!rstN)
        inValid |-> !(hold && flush)
    ) else $error("hold and flush both high on a live load");

endmodule

// ==== hdl/fetchUnit.sv ====
`timescale 1ns/1ns
`include "rv32_defines.svh"

module fetchUnit (
    input  logic             clk,
    input  logic             rstN,
    input  logic             stall,
    input  logic             branchTaken,
    input  logic             jumpTaken,
    input  logic [`XLEN-1:0] branchTarget,
    input  logic [`XLEN-1:0] jumpTarget,
    output logic [`XLEN-1:0] pc
);

    // redirect order follows pipeline age
    // branch in EX/MEM is older than a jump in ID/EX
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= `RESET_PC;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (jumpTaken) begin
            pc <= jumpTarget;
        end else if (!stall) begin
            // sequential fetch, 4 bytes per instruction
            pc <= pc + `XLEN'(4);
        end
    end

    // targets come from top-level adders fed by decoded offsets
    // an odd halfword offset would show up here
    pcAligned: assert property (
        @(posedge clk) disable iff (!rstN)
        pc[1:0] == 2'b00
    ) else $error("pc not word aligned: %h", pc);

endmodule

// ==== hdl/pipelineControlTop.sv ====
`timescale 1ns/1ns
`include "rv32_defines.svh"

module pipelineControlTop (
    input  logic             clk,
    input  logic             rstN,
    output logic [`XLEN-1:0] instrAddr,
    input  logic [`XLEN-1:0] instr,
    input  logic             exBranchCond,
    output logic             exValid,
    output logic [`XLEN-1:0] exPc,
    output logic [`XLEN-1:0] exInstr
);

    logic [`XLEN-1:0]        pc;
    logic [`XLEN-1:0]        jumpTarget;
    logic [`XLEN-1:0]        branchTarget;
    logic                    stall;
    logic                    ifIdFlush;
    logic                    exFlush;
    logic                    branchTaken;
    logic                    jumpTaken;
    rv32Pkg::fetchPayloadT   fetchData;
    logic                    ifIdValid;
    rv32Pkg::fetchPayloadT   ifIdData;
    rv32Pkg::regAddrT        rs1;
    rv32Pkg::regAddrT        rs2;
    logic                    useRs1;
    logic                    useRs2;
    rv32Pkg::decodedPayloadT decoded;
    logic                    idExValid;
    rv32Pkg::decodedPayloadT idExData;
    logic                    exMemValid;
    rv32Pkg::decodedPayloadT exMemData;

    fetchUnit fetchUnit_inst (
        .clk(clk), .rstN(rstN), .stall(stall),
        .branchTaken(branchTaken), .jumpTaken(jumpTaken),
        .branchTarget(branchTarget), .jumpTarget(jumpTarget), .pc(pc)
    );

    // memory read is combinational, instr answers pc this cycle
    assign instrAddr = pc;
    assign fetchData = '{pc: pc, instr: instr};

    // IF/ID holds on stall, fetch is always a live instruction
    pipeStageReg #(.payloadT(rv32Pkg::fetchPayloadT)) ifIdReg (
        .clk(clk), .rstN(rstN), .hold(stall), .flush(ifIdFlush),
        .inValid(1'b1), .inData(fetchData), .outValid(ifIdValid), .outData(ifIdData)
    );

    instrDecoder instrDecoder_inst (
        .ifValid(ifIdValid), .ifPc(ifIdData.pc), .ifInstr(ifIdData.instr),
        .rs1(rs1), .rs2(rs2), .useRs1(useRs1), .useRs2(useRs2), .decoded(decoded)
    );

    // ID/EX never holds, a stall drops a bubble in behind the load
    pipeStageReg #(.payloadT(rv32Pkg::decodedPayloadT)) idExReg (
        .clk(clk), .rstN(rstN), .hold(1'b0), .flush(ifIdFlush || stall),
        .inValid(ifIdValid), .inData(decoded), .outValid(idExValid), .outData(idExData)
    );

    pipeStageReg #(.payloadT(rv32Pkg::decodedPayloadT)) exMemReg (
        .clk(clk), .rstN(rstN), .hold(1'b0), .flush(exFlush),
        .inValid(idExValid), .inData(idExData), .outValid(exMemValid), .outData(exMemData)
    );

    hazardDetection hazardDetection_inst (
        .useRs1(useRs1), .useRs2(useRs2), .rs1(rs1), .rs2(rs2),
        .idValid(idExValid), .idIsLoad(idExData.isLoad), .idRd(idExData.rd),
        .idIsJump(idExData.isJump), .exValid(exMemValid),
        .exIsBranch(exMemData.isBranch), .exBranchCond(exBranchCond),
        .stall(stall), .ifIdFlush(ifIdFlush), .exFlush(exFlush),
        .branchTaken(branchTaken), .jumpTaken(jumpTaken)
    );

    // offsets are signed, the size cast sign-extends them to a full word
    assign jumpTarget   = idExData.pc + `XLEN'(idExData.jumpImm);
    assign branchTarget = exMemData.pc + `XLEN'(exMemData.branchImm);

    assign exValid = exMemValid;
    assign exPc    = exMemData.pc;
    assign exInstr = exMemData.instr;

endmodule

// ==== tb/clockGen.sv ====
`timescale 1ns/1ns

module clockGen (
    output logic clk,
    output logic rstN
);

    // 8 ns period
    initial clk = 1'b0;
    always #4 clk = ~clk;

    // reset low for the first 3 rising edges
    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        #1 rstN = 1'b1;
    end

endmodule

// ==== tb/pipelineControlTb.sv ====
`timescale 1ns/1ns
`include "rv32_defines.svh"

module pipelineControlTb;

    logic             clk;
    logic             genRstN;
    logic             testRstN;
    logic             rstN;
    logic [`XLEN-1:0] instrAddr;
    logic [`XLEN-1:0] instr;
    logic             exBranchCond;
    logic             exValid;
    logic [`XLEN-1:0] exPc;
    logic [`XLEN-1:0] exInstr;

    logic [31:0] mem [0:255];
    logic        takenTbl [0:255];
    // intended jump or branch offset per word address
    int          offTbl [0:255];
    logic [31:0] expPc [0:255];
    logic [31:0] expInstr [0:255];
    int          expGap [0:255];
    logic        outcomes [0:255];
    int          expCount;
    int          idx;
    int          gapCnt;
    int          brIdx;
    int          seed;
    int          waited;
    string       testName;
    logic [31:0] curPc;
    logic [31:0] curInstr;
    int          curGap;

    clockGen clockGen_inst (.clk(clk), .rstN(genRstN));

    assign rstN = genRstN && testRstN;

    pipelineControlTop pipelineControlTop_inst (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
        .exBranchCond(exBranchCond), .exValid(exValid), .exPc(exPc), .exInstr(exInstr)
    );

    // combinational instruction memory
    assign instr = mem[instrAddr[9:2]];

    // head of the expected stream
    assign curPc    = expPc[idx[7:0]];
    assign curInstr = expInstr[idx[7:0]];
    assign curGap   = expGap[idx[7:0]];

    // encoders for the instruction formats used by the programs
    function automatic logic [31:0] encI(input int imm, input int rs1, input int rd,
                                         input logic [6:0] op);
        logic [11:0] i12;
        i12 = imm[11:0];
        return {i12, rs1[4:0], 3'b010 & {3{op == `OPCODE_LOAD}}, rd[4:0], op};
    endfunction

    function automatic logic [31:0] encR(input int rs2, input int rs1, input int rd);
        return {7'b0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], `OPCODE_OP};
    endfunction

    function automatic logic [31:0] encB(input int imm, input int rs2, input int rs1);
        logic [12:0] b;
        b = imm[12:0];
        return {b[12], b[10:5], rs2[4:0], rs1[4:0], 3'b000, b[4:1], b[11], `OPCODE_BRANCH};
    endfunction

    function automatic logic [31:0] encJ(input int imm, input int rd);
        logic [20:0] j;
        j = imm[20:0];
        return {j[20], j[10:1], j[11], j[19:12], rd[4:0], `OPCODE_JAL};
    endfunction

    // does w read register r as a source
    function automatic logic readsReg(input logic [31:0] w, input logic [4:0] r);
        logic [6:0] op;
        op = w[6:0];
        if (op == `OPCODE_OP || op == `OPCODE_BRANCH || op == `OPCODE_STORE) begin
            return (w[19:15] == r) || (w[24:20] == r);
        end
        if (op == `OPCODE_OP_IMM || op == `OPCODE_LOAD) begin
            return w[19:15] == r;
        end
        return 1'b0;
    endfunction

    // reset held while the next program is loaded
    task automatic startTest(input string name);
        testRstN = 1'b0;
        testName = name;
        for (int i = 0; i < 256; i++) begin
            // addi x0, x0, 0
            mem[i] = 32'h0000_0013;
            takenTbl[i] = 1'b0;
            offTbl[i] = 0;
        end
        repeat (3) @(posedge clk);
        #1;
    endtask

    // walk the program in execution order, then release reset and wait
    task automatic runTest(input int limit, input logic randomOutcome);
        logic [31:0] pc;
        logic [31:0] w;
        logic [4:0]  loadRd;
        int          gapNext;
        int          nBr;
        int          cycles;
        pc = `RESET_PC;
        loadRd = 5'd0;
        gapNext = 0;
        nBr = 0;
        expCount = 0;
        while (expCount < limit) begin
            w = mem[pc[9:2]];
            expPc[expCount] = pc;
            expInstr[expCount] = w;
            // one bubble when the previous load feeds this instruction
            if (gapNext == 0 && loadRd != 5'd0 && readsReg(w, loadRd)) begin
                gapNext = 1;
            end
            expGap[expCount] = gapNext;
            expCount++;
            loadRd = (w[6:0] == `OPCODE_LOAD) ? w[11:7] : 5'd0;
            gapNext = 0;
            if (w[6:0] == `OPCODE_JAL) begin
                pc = pc + offTbl[pc[9:2]];
                gapNext = 2;
            end else if (w[6:0] == `OPCODE_BRANCH) begin
                outcomes[nBr] = randomOutcome ? $random(seed) & 1 : takenTbl[pc[9:2]];
                if (outcomes[nBr]) begin
                    pc = pc + offTbl[pc[9:2]];
                    gapNext = 3;
                end else begin
                    pc = pc + 4;
                end
                nBr++;
            end else begin
                pc = pc + 4;
            end
        end
        brIdx = 0;
        testRstN = 1'b1;
        cycles = 0;
        while (idx < expCount) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 400) begin
                $display("%s: expected instruction stream did not finish in time", testName);
                $display("TEST FAIL");
                $fatal(1, "timeout");
            end
        end
    endtask

    // stream position and bubble count since the last valid slot
    always @(posedge clk) begin
        if (!rstN) begin
            idx <= 0;
            gapCnt <= 0;
        end else if (exValid) begin
            idx <= idx + 1;
            gapCnt <= 0;
        end else begin
            gapCnt <= gapCnt + 1;
        end
    end

    // datapath compare result, offered while the branch sits in EX/MEM
    always @(posedge clk) begin
        #1;
        if (rstN && exValid && exInstr[6:0] == `OPCODE_BRANCH) begin
            exBranchCond = outcomes[brIdx[7:0]];
            brIdx = brIdx + 1;
        end else begin
            // ignored by the DUT outside a valid branch
            exBranchCond = $random(seed) & 1;
        end
    end

    resetState: assert property (
        @(posedge clk) !rstN |=> (instrAddr == `RESET_PC && !exValid)
    ) else begin
        $display("ERR %s reset expected pc %h exValid 0 actual pc %h exValid %b",
                 testName, `RESET_PC, $sampled(instrAddr), $sampled(exValid));
        $display("TEST FAIL");
        $fatal(1, "reset check");
    end

    pcOrder: assert property (
        @(posedge clk) disable iff (!rstN)
        (exValid && idx < expCount) |-> (exPc == curPc)
    ) else begin
        $display("ERR %s exPc expected %h actual %h", testName, $sampled(curPc),
                 $sampled(exPc));
        $display("TEST FAIL");
        $fatal(1, "exPc check");
    end

    instrMatch: assert property (
        @(posedge clk) disable iff (!rstN)
        (exValid && idx < expCount) |-> (exInstr == curInstr)
    ) else begin
        $display("ERR %s exInstr expected %h actual %h", testName, $sampled(curInstr),
                 $sampled(exInstr));
        $display("TEST FAIL");
        $fatal(1, "exInstr check");
    end

    // bubbles between valid slots, first slot after reset excluded
    bubbleCount: assert property (
        @(posedge clk) disable iff (!rstN)
        (exValid && idx > 0 && idx < expCount) |-> (gapCnt == curGap)
    ) else begin
        $display("ERR %s bubbles before %h expected %0d actual %0d", testName,
                 $sampled(curPc), $sampled(curGap), $sampled(gapCnt));
        $display("TEST FAIL");
        $fatal(1, "bubble check");
    end

    initial begin
        seed = 32'h84a9a55b;
        testRstN = 1'b0;
        exBranchCond = 1'b0;
        brIdx = 0;
        expCount = 0;
        waited = 0;
        while (genRstN !== 1'b1) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > 10) begin
                $display("reset from the clock generator was never released");
                $display("TEST FAIL");
                $fatal(1, "reset release timeout");
            end
        end

        startTest("straight");
        mem[0] = encI(1, 0, 1, `OPCODE_OP_IMM);
        mem[1] = encI(2, 1, 2, `OPCODE_OP_IMM);
        mem[2] = encR(2, 1, 3);
        mem[3] = encI(-5, 3, 4, `OPCODE_OP_IMM);
        mem[4] = encR(4, 3, 5);
        runTest(10, 1'b0);

        startTest("loadUse");
        mem[0] = encI(0, 0, 5, `OPCODE_LOAD);
        mem[1] = encR(5, 1, 6);
        mem[2] = encI(4, 0, 7, `OPCODE_LOAD);
        mem[3] = encI(1, 1, 8, `OPCODE_OP_IMM);
        mem[4] = encI(8, 0, 0, `OPCODE_LOAD);
        mem[5] = encR(0, 0, 9);
        mem[6] = encI(0, 9, 10, `OPCODE_LOAD);
        mem[7] = encB(8, 1, 10);
        offTbl[7] = 8;
        runTest(12, 1'b0);

        startTest("jal");
        mem[0] = encI(1, 0, 1, `OPCODE_OP_IMM);
        mem[1] = encJ(16, 1);
        offTbl[1] = 16;
        mem[5] = encI(2, 0, 2, `OPCODE_OP_IMM);
        mem[6] = encJ(-24, 0);
        offTbl[6] = -24;
        runTest(9, 1'b0);

        startTest("branch");
        mem[0] = encB(12, 2, 1);
        offTbl[0] = 12;
        takenTbl[0] = 1'b1;
        mem[3] = encB(16, 3, 1);
        offTbl[3] = 16;
        mem[4] = encI(1, 1, 1, `OPCODE_OP_IMM);
        mem[5] = encB(-20, 0, 1);
        offTbl[5] = -20;
        takenTbl[5] = 1'b1;
        runTest(14, 1'b0);

        // loop with a load-use pair and a random exit branch
        startTest("randomLoop");
        mem[0] = encI(1, 1, 1, `OPCODE_OP_IMM);
        mem[1] = encI(0, 1, 2, `OPCODE_LOAD);
        mem[2] = encR(1, 2, 3);
        mem[3] = encB(-12, 3, 1);
        offTbl[3] = -12;
        mem[4] = encJ(-16, 0);
        offTbl[4] = -16;
        runTest(120, 1'b1);

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
hdl/rv32Pkg.sv
hdl/instrDecoder.sv
hdl/hazardDetection.sv
hdl/pipeStageReg.sv
hdl/fetchUnit.sv
hdl/pipelineControlTop.sv
tb/clockGen.sv
tb/pipelineControlTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the pipeline control testbench with Verilator

LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module pipelineControlTb -o simv
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
